/* mm_top.f */
+incdir+source
source/mm_cfg_pkg.sv
source/mm_data_pkg.sv
source/mm_if.sv
source/mm_apb_ctrl.sv
source/mm_w_buffer.sv
source/mm_row_engine.sv
source/mm_z_collector.sv
source/mm_top.sv
test/tb_mm_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_mm_top
FILELIST  = mm_top.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_mm_top.sv */
// --------------------------------------------------
// Directed testbench for the matrix-vector engine
// Expected sums come from a model of the W.X rules
// Rows are always loaded as a full set after a clear
// --------------------------------------------------
`include "mm_defs.svh"

module tb_mm_top
  import mm_cfg_pkg::*;
  import mm_data_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int H = `MM_H;
  localparam int D = `MM_D;
  localparam int NUM_TESTS = 6;
  localparam int WATCHDOG_CYCLES = 2000 + 200 * NUM_TESTS;
  localparam int MAX_POLLS = 40;
  localparam elem_t EMAX = 16'sh7FFF;
  localparam elem_t EMIN = 16'sh8000;

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [`MM_APB_AW-1:0] paddr;
  logic [`MM_APB_DW-1:0] pwdata;
  logic [`MM_APB_DW-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  elem_t       w_m [H][D];  // Weight rows as the host writes them
  elem_t       x_m [D];
  int          cur_width;
  int          cur_height;
  row_mask_t   cur_mask;
  logic [31:0] rng;
  int          errors;
  int          checks;

  mm_top uut (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic elem_t next_elem();
    rng = xorshift(rng);
    return elem_t'(rng[15:0]);
  endfunction

  // Dot product over the programmed width, zero for padded or masked rows
  function automatic acc_t model_row(input int i);
    longint sum;
    sum = 0;
    if (i >= cur_height || cur_mask[i]) begin
      return '0;
    end
    for (int c = 0; c < D; c++) begin
      if (c < cur_width) sum += longint'(w_m[i][c]) * longint'(x_m[c]);
    end
    return acc_t'(sum);  // Keeps the low 32 bits
  endfunction

  task automatic apb_write(input logic [`MM_APB_AW-1:0] addr,
                           input logic [`MM_APB_DW-1:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);  // Write lands on this edge
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [`MM_APB_AW-1:0] addr,
                          output logic [`MM_APB_DW-1:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;  // Middle of the access phase
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_acc(input string what, input acc_t got, input acc_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %0d (0x%h), expected %0d (0x%h)",
               $time, what, got, got, exp, exp);
    end
  endtask

  task automatic check_reg(input string what, input logic [`MM_APB_DW-1:0] got,
                           input logic [`MM_APB_DW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got 0x%h, expected 0x%h", $time, what, got, exp);
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < H; i++) begin
      for (int c = 0; c < D; c++) w_m[i][c] = next_elem();
    end
    for (int c = 0; c < D; c++) x_m[c] = next_elem();
  endtask

  // Size goes first, padding is applied as each row is stored
  task automatic load_matrix();
    apb_write(`MM_REG_CTRL, 32'h2);
    apb_write(`MM_REG_SIZE, {20'h0, 4'(cur_height), 4'h0, 4'(cur_width)});
    for (int i = 0; i < H; i++) begin
      for (int k = 0; k < D / 2; k++) begin
        apb_write(`MM_REG_WSTAGE + 8'(4 * k), {w_m[i][2*k+1], w_m[i][2*k]});
      end
      apb_write(`MM_REG_WLOAD, 32'h0);
    end
    for (int k = 0; k < D / 2; k++) begin
      apb_write(`MM_REG_X + 8'(4 * k), {x_m[2*k+1], x_m[2*k]});
    end
  endtask

  task automatic run_and_wait(input bit extra_start);
    logic [`MM_APB_DW-1:0] status;
    int                    polls;
    apb_write(`MM_REG_CTRL, 32'h1);
    if (extra_start) begin
      apb_read(`MM_REG_STATUS, status);
      check_reg("STATUS while busy", status, 32'h1);
      apb_write(`MM_REG_CTRL, 32'h1);  // Engine busy, must be dropped
    end
    polls  = 0;
    status = '0;
    while (status[1] !== 1'b1 && polls < MAX_POLLS) begin
      apb_read(`MM_REG_STATUS, status);
      polls++;
    end
    if (status[1] !== 1'b1) begin
      errors++;
      $display("Run did not finish: done still low after %0d status reads", polls);
    end
  endtask

  task automatic check_z(input string tag);
    logic [`MM_APB_DW-1:0] data;
    for (int i = 0; i < H; i++) begin
      apb_read(`MM_REG_Z + 8'(4 * i), data);
      check_acc($sformatf("%s Z[%0d]", tag, i), acc_t'(data), model_row(i));
    end
  endtask

  task automatic check_z_cleared(input string tag);
    logic [`MM_APB_DW-1:0] data;
    for (int i = 0; i < H; i++) begin
      apb_read(`MM_REG_Z + 8'(4 * i), data);
      check_acc($sformatf("%s Z[%0d]", tag, i), acc_t'(data), '0);
    end
  endtask

  task automatic test_reset_state();
    logic [`MM_APB_DW-1:0] data;
    check_reg("PREADY/PSLVERR", {30'h0, pslverr, pready}, 32'h1);
    apb_read(`MM_REG_STATUS, data);
    check_reg("STATUS after reset", data, 32'h0);
    check_z_cleared("reset");
  endtask

  task automatic test_full_run();
    logic [`MM_APB_DW-1:0] data;
    cur_width  = D;
    cur_height = H;
    fill_random();
    load_matrix();
    run_and_wait(1'b0);
    check_z("full");
    apb_read(`MM_REG_STATUS, data);
    check_reg("STATUS after run", data, 32'h2);  // Idle with done set
  endtask

  task automatic test_padding();
    cur_width  = 5;
    cur_height = 3;
    fill_random();
    load_matrix();
    run_and_wait(1'b0);
    check_z("padded");
  endtask

  task automatic test_row_mask();
    cur_width  = D;
    cur_height = H;
    cur_mask   = 4'b1010;
    fill_random();
    load_matrix();
    apb_write(`MM_REG_ZMASK, 32'(cur_mask));
    run_and_wait(1'b0);
    check_z("masked");
    cur_mask = '0;
    apb_write(`MM_REG_ZMASK, 32'h0);
  endtask

  task automatic test_back_to_back();
    logic [`MM_APB_DW-1:0] data;
    fill_random();
    load_matrix();
    run_and_wait(1'b0);
    check_z("first run");
    apb_write(`MM_REG_CTRL, 32'h2);
    apb_read(`MM_REG_STATUS, data);
    check_reg("STATUS after clear", data, 32'h0);
    check_z_cleared("clear");
    fill_random();
    load_matrix();
    run_and_wait(1'b1);
    check_z("second run");
  endtask

  // Alternating signs per row; products of 2^30 make the sums wrap
  task automatic test_extremes();
    for (int i = 0; i < H; i++) begin
      for (int c = 0; c < D; c++) begin
        w_m[i][c] = ((i + c) % 2 == 0 || i < 2) ? (i == 1 ? EMIN : EMAX) : EMIN;
      end
    end
    for (int c = 0; c < D; c++) x_m[c] = EMIN;
    load_matrix();
    run_and_wait(1'b0);
    check_z("extreme min");
    for (int c = 0; c < D; c++) x_m[c] = EMAX;
    load_matrix();
    run_and_wait(1'b0);
    check_z("extreme max");
  endtask

  initial begin
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    rst_n      = 1'b0;
    errors     = 0;
    checks     = 0;
    rng        = 32'd99411;
    cur_width  = D;
    cur_height = H;
    cur_mask   = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_full_run();
    test_padding();
    test_row_mask();
    test_back_to_back();
    test_extremes();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* source/mm_top.sv */
// --------------------------------------------------
// Matrix-vector engine with an APB slave port
// PREADY is tied high and PSLVERR low
// --------------------------------------------------
`include "mm_defs.svh"

module mm_top
  import mm_data_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`MM_APB_AW-1:0] paddr_i,
  input  logic [`MM_APB_DW-1:0] pwdata_i,
  output logic [`MM_APB_DW-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  mm_wbuf_if wbuf_if ();
  mm_beat_if beat_if ();

  acc_t [`MM_H-1:0] acc;
  logic [`MM_H-1:0] acc_valid;
  acc_t [`MM_H-1:0] z;
  logic             done;

  assign pready_o  = 1'b1;
  assign pslverr_o = 1'b0;

  mm_apb_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .wbuf         (wbuf_if),
    .beat_x_o     (beat_if.x),
    .beat_valid_o (beat_if.valid),
    .z_i          (z),
    .done_i       (done)
  );

  mm_w_buffer u_wbuf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wbuf    (wbuf_if),
    .w_o     (beat_if.w),
    .first_o (beat_if.first),
    .last_o  (beat_if.last)
  );

  for (genvar i = 0; i < `MM_H; i++) begin : gen_rows
    mm_row_engine u_row (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .w_i         (beat_if.w[i]),
      .x_i         (beat_if.x),
      .valid_i     (beat_if.valid),
      .first_i     (beat_if.first),
      .last_i      (beat_if.last),
      .acc_o       (acc[i]),
      .acc_valid_o (acc_valid[i])
    );
  end

  mm_z_collector u_coll (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (wbuf_if.clear),
    .acc_i       (acc),
    .acc_valid_i (acc_valid),
    .z_o         (z),
    .done_o      (done)
  );

endmodule

/* source/mm_z_collector.sv */
// --------------------------------------------------
// Holds the H row results for the host
// done is set once every row has delivered
// Clear drops the results and done
// --------------------------------------------------
`include "mm_defs.svh"

module mm_z_collector
  import mm_data_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  acc_t [`MM_H-1:0]  acc_i,
  input  logic [`MM_H-1:0]  acc_valid_i,
  output acc_t [`MM_H-1:0]  z_o,
  output logic              done_o
);

  localparam int unsigned H = `MM_H;

  acc_t [H-1:0] z_q;
  logic [H-1:0] got_q;
  logic         done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      z_q    <= '0;
      got_q  <= '0;
      done_q <= 1'b0;
    end else if (clear_i) begin
      z_q    <= '0;
      got_q  <= '0;
      done_q <= 1'b0;
    end else begin
      for (int i = 0; i < H; i++) begin
        if (acc_valid_i[i]) begin
          z_q[i] <= acc_i[i];
        end
      end
      got_q  <= got_q | acc_valid_i;
      done_q <= &(got_q | acc_valid_i);  // Rows normally arrive together
    end
  end

  assign z_o    = z_q;
  assign done_o = done_q;

endmodule

/* source/mm_row_engine.sv */
// --------------------------------------------------
// One multiply-accumulate lane
// Product stage, then accumulate stage; a sum leaves
// two cycles after the beat tagged last
// --------------------------------------------------
module mm_row_engine
  import mm_data_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  elem_t w_i,
  input  elem_t x_i,
  input  logic  valid_i,
  input  logic  first_i,
  input  logic  last_i,
  output acc_t  acc_o,
  output logic  acc_valid_o
);

  acc_t prod_q;
  logic prod_valid_q, prod_first_q, prod_last_q;
  acc_t acc_q;
  logic acc_valid_q;

  // Full 32-bit product, sums wrap
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      prod_q <= acc_t'(w_i) * acc_t'(x_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prod_valid_q <= 1'b0;
      prod_first_q <= 1'b0;
      prod_last_q  <= 1'b0;
      acc_valid_q  <= 1'b0;
    end else begin
      prod_valid_q <= valid_i;
      prod_first_q <= valid_i && first_i;
      prod_last_q  <= valid_i && last_i;
      acc_valid_q  <= prod_valid_q && prod_last_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (prod_valid_q) begin
      acc_q <= prod_first_q ? prod_q : acc_q + prod_q;  // Restart on the first column
    end
  end

  assign acc_o       = acc_q;
  assign acc_valid_o = acc_valid_q;

endmodule

/* source/mm_w_buffer.sv */
// --------------------------------------------------
// Weight row storage, H rows of D elements
// Padding is applied when a row is written, the mask
// when it is read; the pointer wraps after H loads
// --------------------------------------------------
`include "mm_defs.svh"

module mm_w_buffer
  import mm_cfg_pkg::*;
  import mm_data_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  mm_wbuf_if.buffer        wbuf,
  output elem_t [`MM_H-1:0] w_o,
  output logic             first_o,
  output logic             last_o
);

  localparam int unsigned H  = `MM_H;
  localparam int unsigned D  = `MM_D;
  localparam int unsigned RW = $clog2(H);
  localparam int unsigned EW = $clog2(D);

  elem_row_t mem_q [H];
  elem_row_t w_data;
  logic [RW-1:0] row_q;
  logic [EW-1:0] el_q;
  logic          row_valid;

  // Row slots at or beyond height are stored as zero
  assign row_valid = (dim_t'(row_q) < wbuf.height);

  always_comb begin
    for (int c = 0; c < D; c++) begin
      if (dim_t'(c) < wbuf.width && row_valid) begin
        w_data[c] = wbuf.wrow[c];
      end else begin
        w_data[c] = '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wbuf.load) begin
      mem_q[row_q] <= w_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : row_pointer
    if (!rst_ni) begin
      row_q <= '0;
    end else if (wbuf.clear) begin
      row_q <= '0;
    end else if (wbuf.load) begin
      row_q <= (row_q == RW'(H - 1)) ? '0 : row_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : element_counter
    if (!rst_ni) begin
      el_q <= '0;
    end else if (wbuf.clear) begin
      el_q <= '0;
    end else if (wbuf.shift) begin
      el_q <= (el_q == EW'(D - 1)) ? '0 : el_q + 1'b1;
    end
  end

  // One column per shift, masked rows read as zero
  always_comb begin
    for (int i = 0; i < H; i++) begin
      w_o[i] = wbuf.zero_set[i] ? '0 : mem_q[i][el_q];
    end
  end

  assign first_o = (el_q == '0);
  assign last_o  = (el_q == EW'(D - 1));

endmodule

/* source/mm_apb_ctrl.sv */
// --------------------------------------------------
// APB register file and run controller
// No wait states and no error response
// A start while busy is dropped; an accepted start
// also clears the previous results and done
// --------------------------------------------------
`include "mm_defs.svh"

module mm_apb_ctrl
  import mm_cfg_pkg::*;
  import mm_data_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`MM_APB_AW-1:0] paddr_i,
  input  logic [`MM_APB_DW-1:0] pwdata_i,
  output logic [`MM_APB_DW-1:0] prdata_o,
  mm_wbuf_if.ctrl               wbuf,
  output elem_t                 beat_x_o,
  output logic                  beat_valid_o,
  input  acc_t [`MM_H-1:0]      z_i,
  input  logic                  done_i
);

  localparam int unsigned CW = $clog2(`MM_D);
  localparam logic [`MM_APB_AW-1:0] PAGE_MASK = 8'hF0;

  ctrl_state_e state_q, state_d;
  logic [CW-1:0] beat_q;
  logic          last_beat;

  elem_row_t wstage_q;
  elem_row_t x_q;
  dim_t      width_q;
  dim_t      height_q;
  row_mask_t zmask_q;

  logic                  wr_en, rd_en;
  logic                  ctrl_wr, start_ok;
  logic [`MM_APB_AW-1:0] page_addr;
  logic [1:0]            word;

  assign wr_en     = psel_i && penable_i && pwrite_i;
  assign rd_en     = psel_i && penable_i && !pwrite_i;
  assign page_addr = paddr_i & PAGE_MASK;
  assign word      = paddr_i[3:2];  // Word within a register page

  assign ctrl_wr   = wr_en && (paddr_i == `MM_REG_CTRL);
  assign start_ok  = ctrl_wr && pwdata_i[0] && (state_q == IDLE);
  assign last_beat = (beat_q == CW'(`MM_D - 1));

  // Size and mask
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      width_q  <= dim_t'(`MM_D);
      height_q <= dim_t'(`MM_H);
      zmask_q  <= '0;
    end else if (wr_en && paddr_i == `MM_REG_SIZE) begin
      width_q  <= pwdata_i[3:0];
      height_q <= pwdata_i[11:8];
    end else if (wr_en && paddr_i == `MM_REG_ZMASK) begin
      zmask_q  <= pwdata_i[`MM_H-1:0];
    end
  end

  // Staged row and X vector, low half is the even element
  always_ff @(posedge clk_i) begin
    if (wr_en && page_addr == `MM_REG_WSTAGE) begin
      wstage_q[{word, 1'b0}] <= pwdata_i[`MM_EW-1:0];
      wstage_q[{word, 1'b1}] <= pwdata_i[2*`MM_EW-1:`MM_EW];
    end
    if (wr_en && page_addr == `MM_REG_X) begin
      x_q[{word, 1'b0}] <= pwdata_i[`MM_EW-1:0];
      x_q[{word, 1'b1}] <= pwdata_i[2*`MM_EW-1:`MM_EW];
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_ok) state_d = RUN;
      RUN:     if (last_beat) state_d = WAIT;
      WAIT:    if (done_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == RUN && !last_beat) begin
        beat_q <= beat_q + 1'b1;
      end else begin
        beat_q <= '0;
      end
    end
  end

  // Weight buffer side
  assign wbuf.load     = wr_en && (paddr_i == `MM_REG_WLOAD);
  assign wbuf.wrow     = wstage_q;
  assign wbuf.shift    = (state_q == RUN);
  assign wbuf.clear    = (ctrl_wr && pwdata_i[1]) || start_ok;
  assign wbuf.width    = width_q;
  assign wbuf.height   = height_q;
  assign wbuf.zero_set = zmask_q;

  assign beat_valid_o = (state_q == RUN);
  assign beat_x_o     = x_q[beat_q];  // Follows the buffer element counter

  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      if (paddr_i == `MM_REG_STATUS) begin
        prdata_o[0] = (state_q != IDLE);
        prdata_o[1] = done_i;
      end else if (paddr_i == `MM_REG_SIZE) begin
        prdata_o[3:0]  = width_q;
        prdata_o[11:8] = height_q;
      end else if (paddr_i == `MM_REG_ZMASK) begin
        prdata_o[`MM_H-1:0] = zmask_q;
      end else if (page_addr == `MM_REG_Z) begin
        prdata_o = z_i[word];
      end
    end
  end

endmodule

/* source/mm_if.sv */
// --------------------------------------------------
// Internal bundles between controller, weight buffer
// and the row engines
// load and clear are single cycle pulses
// --------------------------------------------------
`include "mm_defs.svh"

interface mm_wbuf_if
  import mm_cfg_pkg::*;
  import mm_data_pkg::*;
();
  logic      load;      // Write wrow at the row pointer
  elem_row_t wrow;
  logic      shift;     // Advance the element stream
  logic      clear;     // Row pointer and element counter back to 0
  dim_t      width;
  dim_t      height;
  row_mask_t zero_set;

  modport ctrl (output load, wrow, shift, clear, width, height, zero_set);
  modport buffer (input load, wrow, shift, clear, width, height, zero_set);
endinterface

interface mm_beat_if
  import mm_data_pkg::*;
();
  elem_t [`MM_H-1:0] w;  // One element per row
  elem_t             x;
  logic              valid;
  logic              first;
  logic              last;

  modport wsrc (output w, first, last);
  modport xsrc (output valid, x);
  modport sink (input w, x, valid, first, last);
endinterface

/* source/mm_data_pkg.sv */
// --------------------------------------------------
// Datapath types of the engine
// Element rows are packed, index 0 is the lowest
// --------------------------------------------------
`include "mm_defs.svh"

package mm_data_pkg;

  typedef logic signed [`MM_EW-1:0] elem_t;
  typedef logic signed [`MM_AW-1:0] acc_t;

  // One staged W row or the X vector
  typedef elem_t [`MM_D-1:0] elem_row_t;

endpackage

/* source/mm_cfg_pkg.sv */
// --------------------------------------------------
// Control side types: size fields, row mask, FSM
// Width and height count 0..8, so values above the
// array size simply mean no padding
// --------------------------------------------------
`include "mm_defs.svh"

package mm_cfg_pkg;

  // Programmed width or height
  typedef logic [3:0] dim_t;

  // One bit per row, set forces the row to zero
  typedef logic [`MM_H-1:0] row_mask_t;

  // Run controller
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,  // D shift beats
    WAIT = 2'd2   // Pipeline drains, waiting for done
  } ctrl_state_e;

endpackage

/* source/mm_defs.svh */
// --------------------------------------------------
// Sizes and APB map of the matrix-vector engine
// The register map assumes H=4 rows and D=8 columns
// Elements are 16-bit signed, sums 32-bit and wrap
// --------------------------------------------------
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

`define MM_H        4    // Rows of W and row engines
`define MM_D        8    // Elements per row and per X vector
`define MM_EW       16   // Element width
`define MM_AW       32   // Accumulator width

`define MM_APB_AW   8
`define MM_APB_DW   32

`define MM_REG_CTRL    8'h00  // bit0 start, bit1 clear
`define MM_REG_STATUS  8'h04  // bit0 busy, bit1 done
`define MM_REG_SIZE    8'h08  // width 3:0, height 11:8
`define MM_REG_ZMASK   8'h0C
`define MM_REG_WSTAGE  8'h10  // 0x10..0x1C, two elements per word
`define MM_REG_WLOAD   8'h20
`define MM_REG_X       8'h30  // 0x30..0x3C
`define MM_REG_Z       8'h50  // 0x50..0x5C

`endif
